// File: hw/cache_geom_pkg.sv
`default_nettype none

package cache_geom_pkg;

  localparam int ways       = 4;
  localparam int sets       = 16;
  localparam int line_words = 4;
  localparam logic [10:0] lfsr_seed = 11'd101;

  typedef logic [15:0]            addr_t;
  typedef logic [7:0]             tag_t;
  typedef logic [3:0]             index_t;
  typedef logic [1:0]             word_idx_t;
  typedef logic [1:0]             way_t;
  typedef logic [ways-1:0]        way_mask_t;
  typedef logic [31:0]            word_t;
  typedef logic [3:0]             be_t;    // msb enables the top byte
  typedef logic [127:0]           line_t;  // word 0 in the top bits
  typedef logic [line_words-1:0]  line_valid_t;

  // lsb position of a word inside a line
  function automatic int unsigned word_lsb(word_idx_t w);
    return (line_words - 1 - w) * $bits(word_t);
  endfunction

  function automatic word_t word_of(line_t l, word_idx_t w);
    return l[word_lsb(w) +: $bits(word_t)];
  endfunction

  function automatic word_t merge_bytes(word_t old_w, word_t new_w, be_t be);
    word_t m;
    for (int b = 0; b < $bits(be_t); b++) begin
      m[b*8 +: 8] = be[b] ? new_w[b*8 +: 8] : old_w[b*8 +: 8];
    end
    return m;
  endfunction

endpackage

`default_nettype wire

// File: hw/mem_bus_pkg.sv
`default_nettype none

package mem_bus_pkg;

  localparam int burst_words    = 4;
  localparam int mem_word_bytes = 4;

  typedef logic [15:0] mem_addr_t;
  typedef logic [31:0] mem_word_t;
  typedef logic [2:0]  burst_cnt_t;   // 0 .. burst_words

endpackage

`default_nettype wire

// File: hw/cache_ifs.sv
`timescale 1ns/1ns
`default_nettype none

// set lookup and tag/word write ports of the arrays
interface store_if import cache_geom_pkg::*; ();
  index_t    index;
  way_mask_t lk_valid;
  way_mask_t lk_dirty;
  way_mask_t lk_lfill;
  tag_t      lk_tag [ways];
  line_t     lk_line [ways];

  logic      tag_write;
  way_t      tag_way;
  tag_t      new_tag;
  logic      new_valid;
  logic      new_dirty;
  logic      new_lfill;

  logic      word_write;
  way_t      word_way;
  word_idx_t word_idx;
  be_t       be;
  word_t     wr_data;

  modport ctrl (
    output index, tag_write, tag_way, new_tag, new_valid, new_dirty, new_lfill,
    output word_write, word_way, word_idx, be, wr_data,
    input  lk_valid, lk_dirty, lk_lfill, lk_tag, lk_line
  );
  modport store (
    input  index, tag_write, tag_way, new_tag, new_valid, new_dirty, new_lfill,
    input  word_write, word_way, word_idx, be, wr_data,
    output lk_valid, lk_dirty, lk_lfill, lk_tag, lk_line
  );
endinterface

interface fill_if import cache_geom_pkg::*; ();
  logic      start;
  way_t      way;
  index_t    index;
  tag_t      tag;
  word_idx_t first_word;
  index_t    look_index;
  tag_t      look_tag;
  word_idx_t look_word;
  logic      hit_write;
  be_t       be;
  word_t     wr_data;
  logic      busy;
  logic      hit;
  word_t     hit_word;

  modport ctrl (
    output start, way, index, tag, first_word, look_index, look_tag, look_word,
    output hit_write, be, wr_data,
    input  busy, hit, hit_word
  );
  modport buffer (
    input  start, way, index, tag, first_word, look_index, look_tag, look_word,
    input  hit_write, be, wr_data,
    output busy, hit, hit_word
  );
endinterface

interface commit_if import cache_geom_pkg::*; ();
  logic   commit;
  way_t   way;
  index_t index;
  line_t  line;
  logic   dirty;

  modport buffer (output commit, way, index, line, dirty);
  modport store  (input  commit, way, index, line, dirty);
endinterface

interface mem_if import cache_geom_pkg::*, mem_bus_pkg::*; ();
  logic      wb_start;
  mem_addr_t wb_addr;   // line base
  line_t     wb_line;
  logic      fill_start;
  mem_addr_t fill_addr; // word aligned, first beat
  logic      wb_done;

  modport ctrl (output wb_start, wb_addr, wb_line, fill_start, fill_addr, input wb_done);
  modport port (input wb_start, wb_addr, wb_line, fill_start, fill_addr, output wb_done);
endinterface

`default_nettype wire

// File: hw/cache_store.sv
`timescale 1ns/1ns
`default_nettype none

module cache_store import cache_geom_pkg::*; (
  input  logic   clock,
  input  logic   reset_n,
  store_if.store st,
  commit_if.store cm
);

  way_mask_t valid_q [sets];
  way_mask_t dirty_q [sets];
  way_mask_t lfill_q [sets];  // way reserved by the linefill buffer
  tag_t      tag_q   [sets][ways];
  line_t     data_q  [sets][ways];

  assign st.lk_valid = valid_q[st.index];
  assign st.lk_dirty = dirty_q[st.index];
  assign st.lk_lfill = lfill_q[st.index];
  assign st.lk_tag   = tag_q[st.index];
  assign st.lk_line  = data_q[st.index];

  always_ff @(posedge clock, negedge reset_n) begin
    if (!reset_n) begin
      for (int s = 0; s < sets; s++) begin
        valid_q[s] <= '0;
        dirty_q[s] <= '0;
        lfill_q[s] <= '0;
      end
    end else begin
      if (st.tag_write) begin
        valid_q[st.index][st.tag_way] <= st.new_valid;
        dirty_q[st.index][st.tag_way] <= st.new_dirty;
        lfill_q[st.index][st.tag_way] <= st.new_lfill;
      end
      if (cm.commit) begin
        valid_q[cm.index][cm.way] <= 1'b1;
        dirty_q[cm.index][cm.way] <= cm.dirty;
        lfill_q[cm.index][cm.way] <= 1'b0;
      end
    end
  end

  always_ff @(posedge clock) begin
    if (st.tag_write)
      tag_q[st.index][st.tag_way] <= st.new_tag;
    if (st.word_write)
      data_q[st.index][st.word_way][word_lsb(st.word_idx) +: $bits(word_t)] <=
        merge_bytes(word_of(data_q[st.index][st.word_way], st.word_idx), st.wr_data, st.be);
    if (cm.commit)
      data_q[cm.index][cm.way] <= cm.line;
  end

  // ctrl never retags the way that is being committed
  a_no_tag_commit_clash: assert property (@(posedge clock) disable iff (!reset_n)
    (st.tag_write && cm.commit) |-> !(st.tag_way == cm.way && st.index == cm.index));

endmodule

`default_nettype wire

// File: hw/linefill_buf.sv
`timescale 1ns/1ns
`default_nettype none

module linefill_buf import cache_geom_pkg::*, mem_bus_pkg::*; (
  input  logic      clock,
  input  logic      reset_n,
  input  mem_word_t mem_rd_data,
  input  logic      mem_rd_valid,
  fill_if.buffer    fl,
  commit_if.buffer  cm
);

  logic        busy;
  way_t        fill_way;
  index_t      fill_index;
  tag_t        fill_tag;
  word_idx_t   wr_ptr;      // wraps within the line
  line_valid_t word_valid;
  logic        fill_dirty;
  line_t       fill_line;
  logic        commit_q;
  logic        capture;
  line_valid_t valid_nx;
  word_t       merged;

  assign capture  = busy && mem_rd_valid;
  assign valid_nx = word_valid | (line_valid_t'(1) << wr_ptr);

  assign fl.busy     = busy;
  assign fl.hit      = busy && (fl.look_index == fill_index) && (fl.look_tag == fill_tag)
                       && word_valid[fl.look_word];
  assign fl.hit_word = word_of(fill_line, fl.look_word);
  assign merged      = merge_bytes(fl.hit_word, fl.wr_data, fl.be);

  always_ff @(posedge clock, negedge reset_n) begin
    if (!reset_n) begin
      busy       <= 1'b0;
      wr_ptr     <= '0;
      word_valid <= '0;
      fill_dirty <= 1'b0;
      commit_q   <= 1'b0;
    end else begin
      commit_q <= capture && (&valid_nx);  // last missing word
      if (fl.start) begin
        busy       <= 1'b1;
        wr_ptr     <= fl.first_word;
        word_valid <= '0;
        fill_dirty <= 1'b0;
      end else if (commit_q) begin
        busy       <= 1'b0;
        word_valid <= '0;
      end else begin
        if (capture) begin
          word_valid <= valid_nx;
          wr_ptr     <= wr_ptr + 1'b1;
        end
        if (fl.hit_write)
          fill_dirty <= 1'b1;
      end
    end
  end

  always_ff @(posedge clock) begin
    if (fl.start) begin
      fill_way   <= fl.way;
      fill_index <= fl.index;
      fill_tag   <= fl.tag;
    end
    if (capture)
      fill_line[word_lsb(wr_ptr) +: $bits(word_t)] <= mem_rd_data;
    if (fl.hit_write)
      fill_line[word_lsb(fl.look_word) +: $bits(word_t)] <= merged;
  end

  assign cm.commit = commit_q;
  assign cm.way    = fill_way;
  assign cm.index  = fill_index;
  assign cm.dirty  = fill_dirty || fl.hit_write;

  // a write landing in the commit cycle goes straight into the line
  always_comb begin
    cm.line = fill_line;
    if (fl.hit_write)
      cm.line[word_lsb(fl.look_word) +: $bits(word_t)] = merged;
  end

  a_commit_full_line: assert property (@(posedge clock) disable iff (!reset_n)
    cm.commit |-> (busy && (&word_valid)));

endmodule

`default_nettype wire

// File: hw/mem_port.sv
`timescale 1ns/1ns
`default_nettype none

module mem_port import cache_geom_pkg::*, mem_bus_pkg::*; (
  input  logic      clock,
  input  logic      reset_n,
  mem_if.port       mem,
  output mem_addr_t mem_addr,
  output logic      mem_rd,
  output logic      mem_wr,
  output mem_word_t mem_wr_data,
  input  logic      mem_waitrequest
);

  line_t      wb_buf;     // remaining writeback words, next one on top
  burst_cnt_t beat_cnt;
  logic       wr_accept;

  assign wr_accept = mem_wr && !mem_waitrequest;

  always_ff @(posedge clock, negedge reset_n) begin
    if (!reset_n) begin
      mem_rd      <= 1'b0;
      mem_wr      <= 1'b0;
      beat_cnt    <= '0;
      mem.wb_done <= 1'b0;
    end else begin
      mem.wb_done <= 1'b0;
      if (mem.fill_start)
        mem_rd <= 1'b1;
      else if (!mem_waitrequest)
        mem_rd <= 1'b0;   // accepted
      if (mem.wb_start) begin
        mem_wr   <= 1'b1;
        beat_cnt <= '0;
      end else if (wr_accept) begin
        beat_cnt <= beat_cnt + 1'b1;
        if (beat_cnt == burst_cnt_t'(burst_words - 1)) begin
          mem_wr      <= 1'b0;
          mem.wb_done <= 1'b1;
        end
      end
    end
  end

  always_ff @(posedge clock) begin
    if (mem.fill_start) begin
      mem_addr <= mem.fill_addr;
    end else if (mem.wb_start) begin
      mem_addr    <= mem.wb_addr;
      mem_wr_data <= mem.wb_line[$bits(line_t)-1 -: $bits(mem_word_t)];
      wb_buf      <= mem.wb_line << $bits(mem_word_t);
    end else if (wr_accept) begin
      mem_addr    <= mem_addr + mem_addr_t'(mem_word_bytes);
      mem_wr_data <= wb_buf[$bits(line_t)-1 -: $bits(mem_word_t)];
      wb_buf      <= wb_buf << $bits(mem_word_t);
    end
  end

  a_rd_wr_exclusive: assert property (@(posedge clock) disable iff (!reset_n)
    !(mem_rd && mem_wr));

endmodule

`default_nettype wire

// File: hw/cache_ctrl.sv
`timescale 1ns/1ns
`default_nettype none

module cache_ctrl import cache_geom_pkg::*, mem_bus_pkg::*; (
  input  logic   clock,
  input  logic   reset_n,
  input  addr_t  cpu_addr,
  input  logic   cpu_rd,
  input  logic   cpu_wr,
  input  be_t    cpu_wr_be,
  input  word_t  cpu_wr_data,
  output logic   cpu_rd_valid,
  output word_t  cpu_rd_data,
  output logic   cpu_waitrequest,
  store_if.ctrl  st,
  fill_if.ctrl   fl,
  mem_if.ctrl    mem
);

  typedef enum logic {IDLE, WRITEBACK} state_t;

  state_t      state;
  state_t      state_nx;
  logic [10:0] lfsr;
  tag_t        cpu_tag;
  index_t      cpu_index;
  word_idx_t   cpu_word;
  way_mask_t   hit_mask;
  way_t        hit_way;
  logic        way_hit;
  logic        hit;
  logic        req;
  way_t        victim;
  logic        victim_dirty;
  way_t        wb_way;     // victim held across the writeback
  way_t        fill_way;
  logic        fill_go;

  assign cpu_tag   = cpu_addr[15:8];
  assign cpu_index = cpu_addr[7:4];
  assign cpu_word  = cpu_addr[3:2];
  assign req       = cpu_rd || cpu_wr;

  always_comb begin
    hit_way = '0;
    for (int w = 0; w < ways; w++) begin
      hit_mask[w] = st.lk_valid[w] && !st.lk_lfill[w] && (st.lk_tag[w] == cpu_tag);
      if (hit_mask[w])
        hit_way = way_t'(w);
    end
  end

  assign way_hit         = |hit_mask;
  assign hit             = way_hit || fl.hit;
  assign cpu_waitrequest = req && !hit;
  assign cpu_rd_valid    = cpu_rd && hit;
  assign cpu_rd_data     = way_hit ? word_of(st.lk_line[hit_way], cpu_word) : fl.hit_word;

  // free way, else clean way after the lfsr pick, else the lfsr pick
  always_comb begin
    logic found;
    way_t j;
    found  = 1'b0;
    victim = lfsr[1:0];
    for (int k = 0; k < ways; k++) begin
      if (!found && !st.lk_valid[k] && !st.lk_lfill[k]) begin
        victim = way_t'(k);
        found  = 1'b1;
      end
    end
    for (int k = 1; k <= ways; k++) begin
      j = lfsr[1:0] + way_t'(k);
      if (!found && !st.lk_dirty[j] && !st.lk_lfill[j]) begin
        victim = j;
        found  = 1'b1;
      end
    end
  end

  assign victim_dirty = st.lk_valid[victim] && st.lk_dirty[victim];

  always_comb begin
    state_nx      = state;
    fill_go       = 1'b0;
    fill_way      = victim;
    fl.hit_write  = 1'b0;
    mem.wb_start  = 1'b0;
    st.word_write = 1'b0;
    st.tag_write  = 1'b0;
    st.tag_way    = victim;
    st.new_tag    = cpu_tag;
    st.new_valid  = 1'b0;
    st.new_dirty  = 1'b0;
    st.new_lfill  = 1'b0;
    case (state)
      IDLE: begin
        if (req && hit) begin
          if (cpu_wr && way_hit) begin
            st.word_write = 1'b1;
            st.tag_write  = 1'b1;
            st.tag_way    = hit_way;
            st.new_valid  = 1'b1;
            st.new_dirty  = 1'b1;
          end
          fl.hit_write = cpu_wr && !way_hit;
        end else if (req && !fl.busy) begin
          st.tag_write = 1'b1;
          if (victim_dirty) begin
            mem.wb_start = 1'b1;  // tag write invalidates the victim
            state_nx     = WRITEBACK;
          end else begin
            fill_go      = 1'b1;
            st.new_lfill = 1'b1;
          end
        end
      end
      WRITEBACK: begin
        if (mem.wb_done) begin
          fill_go      = 1'b1;
          fill_way     = wb_way;
          st.tag_write = 1'b1;
          st.tag_way   = wb_way;
          st.new_lfill = 1'b1;
          state_nx     = IDLE;
        end
      end
      default: state_nx = IDLE;
    endcase
  end

  always_ff @(posedge clock, negedge reset_n) begin
    if (!reset_n) begin
      state  <= IDLE;
      lfsr   <= lfsr_seed;
      wb_way <= '0;
    end else begin
      state <= state_nx;
      if (fill_go)
        lfsr <= {lfsr[1] ^ lfsr[3], lfsr[0] ^ lfsr[2], lfsr[10:2]}; // two steps per fill
      if (mem.wb_start)
        wb_way <= victim;
    end
  end

  assign st.index      = cpu_index;
  assign st.word_way   = hit_way;
  assign st.word_idx   = cpu_word;
  assign st.be         = cpu_wr_be;
  assign st.wr_data    = cpu_wr_data;

  assign fl.start      = fill_go;
  assign fl.way        = fill_way;
  assign fl.index      = cpu_index;
  assign fl.tag        = cpu_tag;
  assign fl.first_word = cpu_word;
  assign fl.look_index = cpu_index;
  assign fl.look_tag   = cpu_tag;
  assign fl.look_word  = cpu_word;
  assign fl.be         = cpu_wr_be;
  assign fl.wr_data    = cpu_wr_data;

  assign mem.fill_start = fill_go;
  assign mem.fill_addr  = mem_addr_t'({cpu_addr[15:2], 2'b00});
  assign mem.wb_addr    = mem_addr_t'({st.lk_tag[victim], cpu_index, 4'b0000});
  assign mem.wb_line    = st.lk_line[victim];

  // only one fill in flight
  a_no_start_while_busy: assert property (@(posedge clock) disable iff (!reset_n)
    (mem.wb_start || mem.fill_start) |-> !fl.busy);

endmodule

`default_nettype wire

// File: hw/cache_top.sv
`timescale 1ns/1ns
`default_nettype none

module cache_top import cache_geom_pkg::*, mem_bus_pkg::*; (
  input  logic      clock,
  input  logic      reset_n,

  input  addr_t     cpu_addr,
  input  logic      cpu_rd,
  input  logic      cpu_wr,
  input  be_t       cpu_wr_be,
  input  word_t     cpu_wr_data,
  output logic      cpu_rd_valid,
  output word_t     cpu_rd_data,
  output logic      cpu_waitrequest,

  output mem_addr_t mem_addr,
  output logic      mem_rd,
  output logic      mem_wr,
  output mem_word_t mem_wr_data,
  input  logic      mem_waitrequest,
  input  mem_word_t mem_rd_data,
  input  logic      mem_rd_valid
);

  store_if  st_if ();
  fill_if   fl_if ();
  commit_if cm_if ();
  mem_if    mem_bus ();

  cache_ctrl i_cache_ctrl (
    .clock           (clock),
    .reset_n         (reset_n),
    .cpu_addr        (cpu_addr),
    .cpu_rd          (cpu_rd),
    .cpu_wr          (cpu_wr),
    .cpu_wr_be       (cpu_wr_be),
    .cpu_wr_data     (cpu_wr_data),
    .cpu_rd_valid    (cpu_rd_valid),
    .cpu_rd_data     (cpu_rd_data),
    .cpu_waitrequest (cpu_waitrequest),
    .st              (st_if),
    .fl              (fl_if),
    .mem             (mem_bus)
  );

  cache_store i_cache_store (
    .clock   (clock),
    .reset_n (reset_n),
    .st      (st_if),
    .cm      (cm_if)
  );

  // fill data goes straight from the bus into the buffer
  linefill_buf i_linefill_buf (
    .clock        (clock),
    .reset_n      (reset_n),
    .mem_rd_data  (mem_rd_data),
    .mem_rd_valid (mem_rd_valid),
    .fl           (fl_if),
    .cm           (cm_if)
  );

  mem_port i_mem_port (
    .clock           (clock),
    .reset_n         (reset_n),
    .mem             (mem_bus),
    .mem_addr        (mem_addr),
    .mem_rd          (mem_rd),
    .mem_wr          (mem_wr),
    .mem_wr_data     (mem_wr_data),
    .mem_waitrequest (mem_waitrequest)
  );

endmodule

`default_nettype wire

// File: tests/mem_model.sv
`timescale 1ns/1ns
`default_nettype none

module mem_model import mem_bus_pkg::*; (
  input  logic      clock,
  input  logic      reset_n,
  input  mem_addr_t mem_addr,
  input  logic      mem_rd,
  input  logic      mem_wr,
  input  mem_word_t mem_wr_data,
  output logic      mem_waitrequest,
  output mem_word_t mem_rd_data,
  output logic      mem_rd_valid
);

  localparam int mem_words = 1 << 14;

  mem_word_t  mem [mem_words];
  integer     seed;
  mem_addr_t  rd_base;
  logic [1:0] rd_ptr;      // wraps inside the line
  burst_cnt_t beats_left;

  function automatic mem_word_t init_pattern(mem_addr_t a);
    return {~a, a ^ 16'h5a3c};
  endfunction

  initial begin
    seed            = 32'hf5bb;
    mem_waitrequest = 1'b0;
    mem_rd_valid    = 1'b0;
    mem_rd_data     = '0;
    rd_base         = '0;
    rd_ptr          = '0;
    beats_left      = '0;
    for (int a = 0; a < mem_words; a++)
      mem[a] = init_pattern(mem_addr_t'(a << 2));
  end

  // bus is stable here, the DUT sees the same values at the next edge
  always @(negedge clock) begin
    if (reset_n && !mem_waitrequest) begin
      if (mem_wr)
        mem[mem_addr[15:2]] = mem_wr_data;
      if (mem_rd) begin
        rd_base    = mem_addr;
        rd_ptr     = mem_addr[3:2];
        beats_left = burst_cnt_t'(burst_words);
      end
    end
  end

  always @(posedge clock) begin
    #1;
    mem_waitrequest = reset_n && (($random(seed) & 3) == 0);
    mem_rd_valid    = 1'b0;
    if (beats_left != 0 && ($random(seed) & 3) != 0) begin  // some gaps
      mem_rd_valid = 1'b1;
      mem_rd_data  = mem[{rd_base[15:4], rd_ptr}];
      rd_ptr       = rd_ptr + 1'b1;
      beats_left   = beats_left - 1'b1;
    end
  end

endmodule

`default_nettype wire

// File: tests/cache_tb.sv
`timescale 1ns/1ns
`default_nettype none

module cache_tb import cache_geom_pkg::*, mem_bus_pkg::*; ();

  localparam int   reset_cycles = 16;
  localparam logic op_rd = 1'b0;
  localparam logic op_wr = 1'b1;

  logic      clock;
  logic      reset_n;
  addr_t     cpu_addr;
  logic      cpu_rd;
  logic      cpu_wr;
  be_t       cpu_wr_be;
  word_t     cpu_wr_data;
  logic      cpu_rd_valid;
  word_t     cpu_rd_data;
  logic      cpu_waitrequest;
  mem_addr_t mem_addr;
  logic      mem_rd;
  logic      mem_wr;
  mem_word_t mem_wr_data;
  logic      mem_waitrequest;
  mem_word_t mem_rd_data;
  logic      mem_rd_valid;

  logic      op_q [$];
  addr_t     addr_q [$];
  be_t       be_q [$];
  word_t     data_q [$];
  logic      hit_q [$];        // must complete in its first cycle
  word_t     shadow [1 << 14];
  int        checks = 0;
  int        errors = 0;
  int        others = 0;
  int        cycles = 0;
  int        cycle_limit = 0;
  int        pending = 0;      // read beats still owed by memory
  int        wb_beat = 0;
  int        wb_beats = 0;
  mem_addr_t wb_base;

  cache_top i_cache_top (
    .clock           (clock),
    .reset_n         (reset_n),
    .cpu_addr        (cpu_addr),
    .cpu_rd          (cpu_rd),
    .cpu_wr          (cpu_wr),
    .cpu_wr_be       (cpu_wr_be),
    .cpu_wr_data     (cpu_wr_data),
    .cpu_rd_valid    (cpu_rd_valid),
    .cpu_rd_data     (cpu_rd_data),
    .cpu_waitrequest (cpu_waitrequest),
    .mem_addr        (mem_addr),
    .mem_rd          (mem_rd),
    .mem_wr          (mem_wr),
    .mem_wr_data     (mem_wr_data),
    .mem_waitrequest (mem_waitrequest),
    .mem_rd_data     (mem_rd_data),
    .mem_rd_valid    (mem_rd_valid)
  );

  mem_model i_mem_model (
    .clock           (clock),
    .reset_n         (reset_n),
    .mem_addr        (mem_addr),
    .mem_rd          (mem_rd),
    .mem_wr          (mem_wr),
    .mem_wr_data     (mem_wr_data),
    .mem_waitrequest (mem_waitrequest),
    .mem_rd_data     (mem_rd_data),
    .mem_rd_valid    (mem_rd_valid)
  );

  always #2 clock = ~clock;

  function automatic word_t init_pattern(mem_addr_t a);
    return {~a, a ^ 16'h5a3c};
  endfunction

  function automatic word_t apply_be(word_t old_w, word_t new_w, be_t be);
    word_t r;
    r = old_w;
    for (int b = 0; b < 4; b++)
      if (be[b])
        r[b*8 +: 8] = new_w[b*8 +: 8];
    return r;
  endfunction

  function automatic addr_t make_addr(tag_t t, index_t i, word_idx_t w);
    return {t, i, w, 2'b00};
  endfunction

  task automatic check_word(input word_t got, input word_t exp, input string what);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("Fail at %0t ns: %s got %h, expected %h", $time, what, got, exp);
    end
  endtask

  task automatic check_addr(input mem_addr_t got, input mem_addr_t exp, input string what);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("Fail at %0t ns: %s got %h, expected %h", $time, what, got, exp);
    end
  endtask

  task automatic check_flag(input logic got, input logic exp, input string what);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("Fail at %0t ns: %s got %b, expected %b", $time, what, got, exp);
    end
  endtask

  task automatic add_entry(input logic op, input addr_t a, input be_t be, input word_t d,
                           input logic hit);
    op_q.push_back(op);
    addr_q.push_back(a);
    be_q.push_back(be);
    data_q.push_back(d);
    hit_q.push_back(hit);
  endtask

  task automatic build_table();
    // read miss then the rest of the line
    add_entry(op_rd, make_addr(8'h12, 4'd1, 2'd2), 4'h0, 32'h0, 1'b0);
    add_entry(op_rd, make_addr(8'h12, 4'd1, 2'd3), 4'h0, 32'h0, 1'b0);
    add_entry(op_rd, make_addr(8'h12, 4'd1, 2'd0), 4'h0, 32'h0, 1'b1);
    add_entry(op_rd, make_addr(8'h12, 4'd1, 2'd1), 4'h0, 32'h0, 1'b1);
    // byte enabled write hits
    add_entry(op_wr, make_addr(8'h12, 4'd1, 2'd0), 4'b0001, 32'hdeadbeef, 1'b1);
    add_entry(op_wr, make_addr(8'h12, 4'd1, 2'd0), 4'b1100, 32'h12345678, 1'b1);
    add_entry(op_rd, make_addr(8'h12, 4'd1, 2'd0), 4'h0, 32'h0, 1'b1);
    add_entry(op_wr, make_addr(8'h12, 4'd1, 2'd3), 4'b1111, 32'h0badf00d, 1'b1);
    add_entry(op_wr, make_addr(8'h12, 4'd1, 2'd3), 4'b0110, 32'h77665544, 1'b1);
    add_entry(op_rd, make_addr(8'h12, 4'd1, 2'd3), 4'h0, 32'h0, 1'b1);
    // write miss lands in the linefill buffer
    add_entry(op_wr, make_addr(8'h34, 4'd2, 2'd1), 4'b1010, 32'hcafef00d, 1'b0);
    add_entry(op_wr, make_addr(8'h34, 4'd2, 2'd2), 4'b0101, 32'h13572468, 1'b0);
    add_entry(op_rd, make_addr(8'h34, 4'd2, 2'd1), 4'h0, 32'h0, 1'b1);
    add_entry(op_rd, make_addr(8'h34, 4'd2, 2'd2), 4'h0, 32'h0, 1'b1);
    add_entry(op_rd, make_addr(8'h34, 4'd2, 2'd3), 4'h0, 32'h0, 1'b1);
    // five tags in set 5 so the last one evicts a dirty line
    add_entry(op_wr, make_addr(8'h40, 4'd5, 2'd0), 4'b1111, 32'ha0a0a0a0, 1'b0);
    add_entry(op_wr, make_addr(8'h41, 4'd5, 2'd1), 4'b0011, 32'ha1a1a1a1, 1'b0);
    add_entry(op_wr, make_addr(8'h42, 4'd5, 2'd2), 4'b1100, 32'ha2a2a2a2, 1'b0);
    add_entry(op_wr, make_addr(8'h43, 4'd5, 2'd3), 4'b1111, 32'ha3a3a3a3, 1'b0);
    add_entry(op_wr, make_addr(8'h44, 4'd5, 2'd0), 4'b1001, 32'ha4a4a4a4, 1'b0);
    add_entry(op_rd, make_addr(8'h40, 4'd5, 2'd0), 4'h0, 32'h0, 1'b0);
    add_entry(op_rd, make_addr(8'h41, 4'd5, 2'd1), 4'h0, 32'h0, 1'b0);
    add_entry(op_rd, make_addr(8'h42, 4'd5, 2'd2), 4'h0, 32'h0, 1'b0);
    add_entry(op_rd, make_addr(8'h43, 4'd5, 2'd3), 4'h0, 32'h0, 1'b0);
    add_entry(op_rd, make_addr(8'h44, 4'd5, 2'd0), 4'h0, 32'h0, 1'b0);
    add_entry(op_rd, make_addr(8'h41, 4'd5, 2'd3), 4'h0, 32'h0, 1'b0);
    // earlier lines are still resident
    add_entry(op_rd, make_addr(8'h12, 4'd1, 2'd2), 4'h0, 32'h0, 1'b1);
    add_entry(op_wr, make_addr(8'h34, 4'd2, 2'd0), 4'b1111, 32'h5ca1ab1e, 1'b1);
    add_entry(op_rd, make_addr(8'h34, 4'd2, 2'd0), 4'h0, 32'h0, 1'b1);
  endtask

  task automatic wait_quiet();
    while (pending != 0 || mem_rd || mem_wr) begin
      @(posedge clock);
      #1;
    end
  endtask

  task automatic run_entry(input int i);
    logic done;
    logic first;
    logic got_hit;
    if (hit_q[i]) begin
      cpu_rd = 1'b0;
      cpu_wr = 1'b0;
      wait_quiet();
    end
    cpu_addr    = addr_q[i];
    cpu_rd      = (op_q[i] == op_rd);
    cpu_wr      = (op_q[i] == op_wr);
    cpu_wr_be   = be_q[i];
    cpu_wr_data = data_q[i];
    done    = 1'b0;
    first   = 1'b1;
    got_hit = 1'b0;
    while (!done) begin
      @(negedge clock);
      if (!cpu_waitrequest) begin
        done    = 1'b1;
        got_hit = first;
      end
      first = 1'b0;
    end
    if (hit_q[i])
      check_flag(got_hit, 1'b1, "hit without wait");
    if (op_q[i] == op_rd) begin
      check_flag(cpu_rd_valid, 1'b1, "cpu_rd_valid");
      check_word(cpu_rd_data, shadow[addr_q[i][15:2]], "cpu read data");
    end else begin
      shadow[addr_q[i][15:2]] = apply_be(shadow[addr_q[i][15:2]], data_q[i], be_q[i]);
    end
    @(posedge clock);
    #1;
  endtask

  // memory side bookkeeping sampled where the bus is stable
  always @(negedge clock) begin
    if (reset_n) begin
      if (mem_rd && !mem_waitrequest)
        pending = pending + burst_words;
      if (mem_rd_valid)
        pending = pending - 1;
      if (mem_wr && !mem_waitrequest) begin
        if (wb_beat == 0)
          wb_base = {mem_addr[15:8], cpu_addr[7:4], 4'h0}; // victim sits in the missing set
        check_addr(mem_addr, wb_base + mem_addr_t'(wb_beat * mem_word_bytes), "writeback addr");
        check_word(mem_wr_data, shadow[mem_addr[15:2]], "writeback data");
        wb_beat = (wb_beat + 1) % burst_words;
        wb_beats++;
      end
    end
  end

  always @(posedge clock) begin
    cycles++;
    if (cycle_limit != 0 && cycles > cycle_limit) begin
      $display("timeout after %0d cycles, a request or burst never finished", cycles);
      $display("%0d checks, %0d value errors, %0d other errors", checks, errors, others);
      $display("Verification failed");
      $finish;
    end
  end

  initial begin
    clock       = 1'b0;
    reset_n     = 1'b0;
    cpu_addr    = '0;
    cpu_rd      = 1'b0;
    cpu_wr      = 1'b0;
    cpu_wr_be   = '0;
    cpu_wr_data = '0;
    for (int a = 0; a < (1 << 14); a++)
      shadow[a] = init_pattern(mem_addr_t'(a << 2));
    build_table();
    cycle_limit = op_q.size() * 64 + reset_cycles;
    repeat (reset_cycles) @(posedge clock);
    #1 reset_n = 1'b1;
    @(negedge clock);
    check_flag(mem_rd, 1'b0, "mem_rd after reset");
    check_flag(mem_wr, 1'b0, "mem_wr after reset");
    check_flag(cpu_rd_valid, 1'b0, "cpu_rd_valid idle");
    check_flag(cpu_waitrequest, 1'b0, "cpu_waitrequest idle");
    @(posedge clock);
    #1;
    for (int i = 0; i < op_q.size(); i++)
      run_entry(i);
    cpu_rd = 1'b0;
    cpu_wr = 1'b0;
    wait_quiet();
    if (wb_beats == 0 || wb_beats % burst_words != 0) begin
      others++;
      $display("no complete writeback burst was seen, %0d write beats", wb_beats);
    end
    $display("%0d checks, %0d value errors, %0d other errors", checks, errors, others);
    if (errors == 0 && others == 0) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: build.f
hw/cache_geom_pkg.sv
hw/mem_bus_pkg.sv
hw/cache_ifs.sv
hw/cache_store.sv
hw/linefill_buf.sv
hw/mem_port.sv
hw/cache_ctrl.sv
hw/cache_top.sv
tests/mem_model.sv
tests/cache_tb.sv

// File: Bender.yml
package:
  name: wb_dcache

sources:
  - hw/cache_geom_pkg.sv
  - hw/mem_bus_pkg.sv
  - hw/cache_ifs.sv
  - hw/cache_store.sv
  - hw/linefill_buf.sv
  - hw/mem_port.sv
  - hw/cache_ctrl.sv
  - hw/cache_top.sv
  - target: test
    files:
      - tests/mem_model.sv
      - tests/cache_tb.sv
